/* logic/rp_bridge_pkg.sv */
/*
 * Shared definitions for the root-port register bridge.
 * Register offsets, FIFO sizing and the packed request and FIFO entry
 * layouts used by the register blocks and the top level.
 */
package rp_bridge_pkg;

  localparam int CRA_ADDR_W = 12;              // word address, byte bits 13:2
  localparam int CRA_DATA_W = 32;

  // transmit registers, full byte address compare
  localparam logic [15:0] TX_DATA_LO_ADDR = 16'h2000;
  localparam logic [15:0] TX_DATA_HI_ADDR = 16'h2004;
  localparam logic [15:0] TX_CTRL_ADDR    = 16'h2008;

  // receive registers, low address byte only
  localparam logic [7:0] RX_STATUS_OFS  = 8'h10;
  localparam logic [7:0] RX_DATA_LO_OFS = 8'h14;
  localparam logic [7:0] RX_DATA_HI_OFS = 8'h18;

  localparam int TX_FIFO_DEPTH_LOG2 = 5;
  localparam int RX_FIFO_DEPTH_LOG2 = 4;
  localparam int TX_FULL_LEVEL      = 8;       // full flag above this count

  typedef struct packed {
    logic [CRA_ADDR_W-1:0]   addr;
    logic [CRA_DATA_W-1:0]   wdata;
    logic [CRA_DATA_W/8-1:0] be;
  } cra_req_t;

  typedef struct packed {
    logic        eop;
    logic        sop;
    logic [31:0] data_hi;
    logic [31:0] data_lo;
  } tx_fifo_word_t;

  typedef struct packed {
    logic         half_empty;                  // upper quadword unused
    logic         eop;
    logic         sop;
    logic [127:0] data;
  } rx_fifo_word_t;

  typedef enum logic [2:0] {
    IDLE, POP, PIPE, LOAD_LO, WAIT_LO, LOAD_HI, WAIT_HI
  } rx_state_t;

endpackage

/* logic/rp_sync_fifo.sv */
/*
 * Single-clock FIFO with a two-stage read path (memory stage plus output
 * register), so data shows two edges after the read strobe and holds.
 * Pushes when full and pops when empty are dropped.
 */
`timescale 1ns/10ps

module rp_sync_fifo #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_LOG2 = 4,
  parameter int LEVEL      = 8
) (
  input  logic                  CraClk_i,
  input  logic                  CraRstn_i,
  input  logic                  wr_i,
  input  logic [WIDTH-1:0]      wdata_i,
  input  logic                  rd_i,
  output logic [WIDTH-1:0]      rdata_o,
  output logic                  empty_o,
  output logic [DEPTH_LOG2:0]   count_o,
  output logic                  above_level_o
);

  logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
  logic [WIDTH-1:0]      mem_q;                 // first read stage
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic                  do_wr;
  logic                  do_rd;

  // count top bit alone means completely full
  assign do_wr         = wr_i & ~count_o[DEPTH_LOG2];
  assign do_rd         = rd_i & ~empty_o;
  assign empty_o       = (count_o == '0);
  assign above_level_o = (count_o > (DEPTH_LOG2+1)'(LEVEL));

  always_ff @(posedge CraClk_i)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata_i;
  end

  always_ff @(posedge CraClk_i or negedge CraRstn_i)
  begin
    if (!CraRstn_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;  // idle or push and pop together
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read pipeline
  always_ff @(posedge CraClk_i or negedge CraRstn_i)
  begin
    if (!CraRstn_i)
    begin
      mem_q   <= '0;
      rdata_o <= '0;
    end
    else
    begin
      if (do_rd)
        mem_q <= mem[rd_ptr];
      rdata_o <= mem_q;             // holds while no new pop
    end
  end

endmodule

/* logic/rp_tx_regs.sv */
/*
 * Transmit side register file. The host writes two data words and then
 * the control word; each control write pushes one quadword entry into
 * the transmit FIFO, and an entry with eop raises TLP ready.
 */
`timescale 1ns/10ps

module rp_tx_regs (
  input  logic                         CraClk_i,
  input  logic                         CraRstn_i,
  input  rp_bridge_pkg::cra_req_t      cra_req_i,
  input  logic                         cra_wr_i,
  input  logic                         tlp_ack_i,
  output logic                         push_o,
  output rp_bridge_pkg::tx_fifo_word_t push_word_o,
  output logic                         tlp_ready_o
);

  logic [15:0]                         byte_addr;
  logic                                wr_lo;
  logic                                wr_hi;
  logic                                wr_ctl;
  logic [rp_bridge_pkg::CRA_DATA_W-1:0] data_lo_q;
  logic [rp_bridge_pkg::CRA_DATA_W-1:0] data_hi_q;
  logic [1:0]                          ctl_q;     // bit 1 eop, bit 0 sop

  // byte-enabled merge, every lane on its own enable
  function automatic logic [rp_bridge_pkg::CRA_DATA_W-1:0] merge_lanes(
    input logic [rp_bridge_pkg::CRA_DATA_W-1:0]   cur,
    input logic [rp_bridge_pkg::CRA_DATA_W-1:0]   wdata,
    input logic [rp_bridge_pkg::CRA_DATA_W/8-1:0] be
  );
    logic [rp_bridge_pkg::CRA_DATA_W-1:0] res;
    res = cur;
    for (int i = 0; i < rp_bridge_pkg::CRA_DATA_W/8; i++)
    begin
      if (be[i])
        res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  assign byte_addr = {2'b00, cra_req_i.addr, 2'b00};
  assign wr_lo     = cra_wr_i & (byte_addr == rp_bridge_pkg::TX_DATA_LO_ADDR);
  assign wr_hi     = cra_wr_i & (byte_addr == rp_bridge_pkg::TX_DATA_HI_ADDR);
  assign wr_ctl    = cra_wr_i & (byte_addr == rp_bridge_pkg::TX_CTRL_ADDR);

  always_ff @(posedge CraClk_i or negedge CraRstn_i)
  begin
    if (!CraRstn_i)
    begin
      data_lo_q <= '0;
      data_hi_q <= '0;
      ctl_q     <= '0;
      push_o    <= 1'b0;
    end
    else
    begin
      if (wr_lo)
        data_lo_q <= merge_lanes(data_lo_q, cra_req_i.wdata, cra_req_i.be);
      if (wr_hi)
        data_hi_q <= merge_lanes(data_hi_q, cra_req_i.wdata, cra_req_i.be);
      if (wr_ctl & cra_req_i.be[0])
        ctl_q <= cra_req_i.wdata[1:0];
      push_o <= wr_ctl;             // push sees the updated registers
    end
  end

  assign push_word_o.eop     = ctl_q[1];
  assign push_word_o.sop     = ctl_q[0];
  assign push_word_o.data_hi = data_hi_q;
  assign push_word_o.data_lo = data_lo_q;

  // set beats ack in the same cycle
  always_ff @(posedge CraClk_i or negedge CraRstn_i)
  begin
    if (!CraRstn_i)
      tlp_ready_o <= 1'b0;
    else if (push_o & ctl_q[1])
      tlp_ready_o <= 1'b1;
    else if (tlp_ack_i)
      tlp_ready_o <= 1'b0;
  end

endmodule

/* logic/rp_rx_cpl_reader.sv */
/*
 * Completion readout. Pops 128-bit entries from the receive FIFO and
 * presents them a quadword at a time in the data registers, with sop/eop
 * and the fill snapshot in the status register. Reading data-high advances.
 */
`timescale 1ns/10ps

module rp_rx_cpl_reader (
  input  logic                                CraClk_i,
  input  logic                                CraRstn_i,
  input  rp_bridge_pkg::cra_req_t             cra_req_i,
  input  logic                                cra_rd_i,
  input  rp_bridge_pkg::rx_fifo_word_t        fifo_rdata_i,
  input  logic                                fifo_empty_i,
  input  logic [rp_bridge_pkg::RX_FIFO_DEPTH_LOG2:0] fifo_count_i,
  output logic                                fifo_rd_o,
  output logic [rp_bridge_pkg::CRA_DATA_W-1:0] cra_rdata_o,
  output logic                                cra_rvalid_o
);

  rp_bridge_pkg::rx_state_t state_q;
  rp_bridge_pkg::rx_state_t state_d;

  logic [7:0]  low_addr;
  logic        rd_hi;                           // host read of data-high
  logic        status_rd;
  logic        load_lo;
  logic        load_hi;
  logic [31:0] data_lo_q;
  logic [31:0] data_hi_q;
  logic        sop_q;
  logic        eop_q;
  logic [7:0]  cnt_snap_q;
  logic [31:0] status_w;
  logic [31:0] rdata_d;

  assign low_addr  = {cra_req_i.addr[5:0], 2'b00};
  assign rd_hi     = cra_rd_i & (low_addr == rp_bridge_pkg::RX_DATA_HI_OFS);
  assign status_rd = cra_rd_i & (low_addr == rp_bridge_pkg::RX_STATUS_OFS);

  //////////////////////////////////////////////////
  // readout FSM
  always_ff @(posedge CraClk_i or negedge CraRstn_i)
  begin
    if (!CraRstn_i)
      state_q <= rp_bridge_pkg::IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      rp_bridge_pkg::IDLE:
        if (!fifo_empty_i)
          state_d = rp_bridge_pkg::POP;
      rp_bridge_pkg::POP:     state_d = rp_bridge_pkg::PIPE;
      rp_bridge_pkg::PIPE:    state_d = rp_bridge_pkg::LOAD_LO;  // fifo read latency
      rp_bridge_pkg::LOAD_LO: state_d = rp_bridge_pkg::WAIT_LO;
      rp_bridge_pkg::WAIT_LO:
      begin
        if (rd_hi & fifo_rdata_i.eop & fifo_rdata_i.half_empty)
          state_d = rp_bridge_pkg::IDLE;
        else if (rd_hi)
          state_d = rp_bridge_pkg::LOAD_HI;
      end
      rp_bridge_pkg::LOAD_HI: state_d = rp_bridge_pkg::WAIT_HI;
      rp_bridge_pkg::WAIT_HI:
      begin
        if (rd_hi & fifo_rdata_i.eop)
          state_d = rp_bridge_pkg::IDLE;
        else if (rd_hi)
          state_d = rp_bridge_pkg::POP;   // next entry of the packet
      end
      default: state_d = rp_bridge_pkg::IDLE;
    endcase
  end

  assign fifo_rd_o = (state_q == rp_bridge_pkg::POP);
  assign load_lo   = (state_q == rp_bridge_pkg::LOAD_LO);
  assign load_hi   = (state_q == rp_bridge_pkg::LOAD_HI);

  //////////////////////////////////////////////////
  // data and status registers
  always_ff @(posedge CraClk_i or negedge CraRstn_i)
  begin
    if (!CraRstn_i)
    begin
      data_lo_q  <= '0;
      data_hi_q  <= '0;
      sop_q      <= 1'b0;
      eop_q      <= 1'b0;
      cnt_snap_q <= '0;
    end
    else
    begin
      if (load_lo)
      begin
        data_lo_q <= fifo_rdata_i.data[31:0];
        data_hi_q <= fifo_rdata_i.data[63:32];
      end
      else if (load_hi)
      begin
        data_lo_q <= fifo_rdata_i.data[95:64];
        data_hi_q <= fifo_rdata_i.data[127:96];
      end

      if (load_lo & fifo_rdata_i.sop)
        sop_q <= 1'b1;
      else if (load_hi | status_rd)
        sop_q <= 1'b0;

      // eop only on the last used quadword
      if ((load_lo & fifo_rdata_i.eop & fifo_rdata_i.half_empty) |
          (load_hi & fifo_rdata_i.eop & ~fifo_rdata_i.half_empty))
        eop_q <= 1'b1;
      else if (load_lo | status_rd)
        eop_q <= 1'b0;

      if (fifo_rd_o)
        cnt_snap_q <= 8'(fifo_count_i);   // count before the pop lands
    end
  end

  assign status_w = {16'h0, cnt_snap_q, 6'h0, eop_q, sop_q};

  // host read path
  always_comb
  begin
    case (low_addr)
      rp_bridge_pkg::RX_STATUS_OFS:  rdata_d = status_w;
      rp_bridge_pkg::RX_DATA_LO_OFS: rdata_d = data_lo_q;
      rp_bridge_pkg::RX_DATA_HI_OFS: rdata_d = data_hi_q;
      default:                       rdata_d = '0;
    endcase
  end

  always_ff @(posedge CraClk_i or negedge CraRstn_i)
  begin
    if (!CraRstn_i)
    begin
      cra_rdata_o  <= '0;
      cra_rvalid_o <= 1'b0;
    end
    else
    begin
      if (cra_rd_i)
        cra_rdata_o <= rdata_d;
      cra_rvalid_o <= cra_rd_i;
    end
  end

endmodule

/* logic/rp_bridge_top.sv */
/*
 * Root-port register bridge top level. Ties the transmit registers and
 * the receive readout to their FIFOs; the host sees a plain strobe bus.
 */
`timescale 1ns/10ps

module rp_bridge_top (
  input  logic                                 CraClk_i,
  input  logic                                 CraRstn_i,
  input  rp_bridge_pkg::cra_req_t              cra_req_i,
  input  logic                                 cra_wr_i,
  input  logic                                 cra_rd_i,
  input  logic                                 tx_fifo_rd_i,
  input  logic                                 tlp_ack_i,
  input  logic                                 rx_fifo_wr_i,
  input  rp_bridge_pkg::rx_fifo_word_t         rx_fifo_data_i,
  output logic [rp_bridge_pkg::CRA_DATA_W-1:0] cra_rdata_o,
  output logic                                 cra_rvalid_o,
  output rp_bridge_pkg::tx_fifo_word_t         tx_fifo_data_o,
  output logic                                 tlp_ready_o,
  output logic                                 tx_fifo_full_o
);

  logic                                       tx_push;
  rp_bridge_pkg::tx_fifo_word_t               tx_push_word;
  logic                                       rx_pop;
  rp_bridge_pkg::rx_fifo_word_t               rx_rdata;
  logic                                       rx_empty;
  logic [rp_bridge_pkg::RX_FIFO_DEPTH_LOG2:0] rx_count;

  //////////////////////////////////////////////////
  // transmit path
  rp_tx_regs u_tx_regs (
    .CraClk_i    (CraClk_i),
    .CraRstn_i   (CraRstn_i),
    .cra_req_i   (cra_req_i),
    .cra_wr_i    (cra_wr_i),
    .tlp_ack_i   (tlp_ack_i),
    .push_o      (tx_push),
    .push_word_o (tx_push_word),
    .tlp_ready_o (tlp_ready_o)
  );

  rp_sync_fifo #(
    .WIDTH      ($bits(rp_bridge_pkg::tx_fifo_word_t)),
    .DEPTH_LOG2 (rp_bridge_pkg::TX_FIFO_DEPTH_LOG2),
    .LEVEL      (rp_bridge_pkg::TX_FULL_LEVEL)
  ) u_tx_fifo (
    .CraClk_i      (CraClk_i),
    .CraRstn_i     (CraRstn_i),
    .wr_i          (tx_push),
    .wdata_i       (tx_push_word),
    .rd_i          (tx_fifo_rd_i),
    .rdata_o       (tx_fifo_data_o),
    .empty_o       (),                  // transaction layer tracks ready
    .count_o       (),
    .above_level_o (tx_fifo_full_o)
  );

  //////////////////////////////////////////////////
  // receive path
  rp_sync_fifo #(
    .WIDTH      ($bits(rp_bridge_pkg::rx_fifo_word_t)),
    .DEPTH_LOG2 (rp_bridge_pkg::RX_FIFO_DEPTH_LOG2)
  ) u_rx_fifo (
    .CraClk_i      (CraClk_i),
    .CraRstn_i     (CraRstn_i),
    .wr_i          (rx_fifo_wr_i),
    .wdata_i       (rx_fifo_data_i),
    .rd_i          (rx_pop),
    .rdata_o       (rx_rdata),
    .empty_o       (rx_empty),
    .count_o       (rx_count),
    .above_level_o ()
  );

  rp_rx_cpl_reader u_rx_reader (
    .CraClk_i     (CraClk_i),
    .CraRstn_i    (CraRstn_i),
    .cra_req_i    (cra_req_i),
    .cra_rd_i     (cra_rd_i),
    .fifo_rdata_i (rx_rdata),
    .fifo_empty_i (rx_empty),
    .fifo_count_i (rx_count),
    .fifo_rd_o    (rx_pop),
    .cra_rdata_o  (cra_rdata_o),
    .cra_rvalid_o (cra_rvalid_o)
  );

endmodule

/* dv/rp_bridge_tb.sv */
/*
 * Directed testbench for the root-port register bridge. Drives the host
 * register bus, drains the transmit FIFO, fills the receive FIFO and
 * checks every response against the register map rules.
 */
`timescale 1ns/10ps

module rp_bridge_tb;

  localparam int TIMEOUT_CYCLES = 3000;  // six tests of up to 400 cycles plus margin

  logic                         cra_clk;
  logic                         cra_rstn;
  rp_bridge_pkg::cra_req_t      cra_req;
  logic                         cra_wr;
  logic                         cra_rd;
  logic                         tx_fifo_rd;
  logic                         tlp_ack;
  logic                         rx_fifo_wr;
  rp_bridge_pkg::rx_fifo_word_t rx_fifo_data;
  logic [31:0]                  cra_rdata;
  logic                         cra_rvalid;
  rp_bridge_pkg::tx_fifo_word_t tx_fifo_data;
  logic                         tlp_ready;
  logic                         tx_fifo_full;

  int          error_count = 0;
  int          cycle_count = 0;
  logic [31:0] model_lo;                  // expected transmit data registers
  logic [31:0] model_hi;

  rp_bridge_top UUT (
    .CraClk_i       (cra_clk),
    .CraRstn_i      (cra_rstn),
    .cra_req_i      (cra_req),
    .cra_wr_i       (cra_wr),
    .cra_rd_i       (cra_rd),
    .tx_fifo_rd_i   (tx_fifo_rd),
    .tlp_ack_i      (tlp_ack),
    .rx_fifo_wr_i   (rx_fifo_wr),
    .rx_fifo_data_i (rx_fifo_data),
    .cra_rdata_o    (cra_rdata),
    .cra_rvalid_o   (cra_rvalid),
    .tx_fifo_data_o (tx_fifo_data),
    .tlp_ready_o    (tlp_ready),
    .tx_fifo_full_o (tx_fifo_full)
  );

  initial
  begin
    cra_clk = 1'b0;
    forever #10 cra_clk = ~cra_clk;
  end

  always @(posedge cra_clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests still running after %0d cycles", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_tx_word(input string name, input rp_bridge_pkg::tx_fifo_word_t got,
                               input rp_bridge_pkg::tx_fifo_word_t exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // expected values from the register map
  function automatic logic [31:0] lane_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (new_val & mask) | (old_val & ~mask);
  endfunction

  function automatic logic [31:0] status_word(input logic [7:0] count, input logic eop,
                                              input logic sop);
    logic [31:0] word;
    word       = 32'h0;
    word[15:8] = count;
    word[1]    = eop;
    word[0]    = sop;
    return word;
  endfunction

  function automatic logic [127:0] random_128();
    logic [127:0] val;
    val[31:0]   = $urandom();
    val[63:32]  = $urandom();
    val[95:64]  = $urandom();
    val[127:96] = $urandom();
    return val;
  endfunction

  //////////////////////////////////////////////////
  // bus tasks enter and leave 2 ns after a rising edge
  task automatic next_cycle();
    @(posedge cra_clk);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic write_reg(input logic [15:0] byte_addr, input logic [31:0] data,
                           input logic [3:0] be);
    cra_req.addr  = byte_addr[13:2];
    cra_req.wdata = data;
    cra_req.be    = be;
    cra_wr        = 1'b1;
    next_cycle();
    cra_wr        = 1'b0;
  endtask

  task automatic expect_read(input logic [15:0] byte_addr, input string name,
                             input logic [31:0] exp);
    cra_req.addr = byte_addr[13:2];
    cra_req.be   = 4'hf;
    cra_rd       = 1'b1;
    next_cycle();
    cra_rd       = 1'b0;
    check_bit("cra_rvalid_o", cra_rvalid, 1'b1);
    check_word(name, cra_rdata, exp);
  endtask

  task automatic pop_tx();
    tx_fifo_rd = 1'b1;
    next_cycle();
    tx_fifo_rd = 1'b0;
    next_cycle();                         // second read stage
  endtask

  task automatic push_rx(input rp_bridge_pkg::rx_fifo_word_t entry);
    rx_fifo_data = entry;
    rx_fifo_wr   = 1'b1;
    next_cycle();
    rx_fifo_wr   = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // tests
  task automatic reset_values();
    expect_read({8'h00, rp_bridge_pkg::RX_STATUS_OFS}, "rx status", 32'h0);
    check_bit("tlp_ready_o", tlp_ready, 1'b0);
    check_bit("tx_fifo_full_o", tx_fifo_full, 1'b0);
    expect_read(16'h001c, "unknown offset", 32'h0);
  endtask

  task automatic tx_lane_merge();
    logic [31:0]                  patch;
    rp_bridge_pkg::tx_fifo_word_t exp;
    model_lo = $urandom();
    model_hi = $urandom();
    write_reg(rp_bridge_pkg::TX_DATA_LO_ADDR, model_lo, 4'hf);
    write_reg(rp_bridge_pkg::TX_DATA_HI_ADDR, model_hi, 4'hf);
    patch = $urandom();
    write_reg(rp_bridge_pkg::TX_DATA_LO_ADDR, patch, 4'b0101);
    model_lo = lane_merge(model_lo, patch, 4'b0101);
    patch = $urandom();
    write_reg(rp_bridge_pkg::TX_DATA_HI_ADDR, patch, 4'b0100);  // lane 2 only
    model_hi = lane_merge(model_hi, patch, 4'b0100);
    patch = $urandom();
    write_reg(rp_bridge_pkg::TX_DATA_HI_ADDR, patch, 4'b1000);
    model_hi = lane_merge(model_hi, patch, 4'b1000);
    write_reg(rp_bridge_pkg::TX_CTRL_ADDR, 32'h1, 4'h1);         // sop
    next_cycle();
    pop_tx();
    exp.eop     = 1'b0;
    exp.sop     = 1'b1;
    exp.data_hi = model_hi;
    exp.data_lo = model_lo;
    check_tx_word("tx_fifo_data_o", tx_fifo_data, exp);
    check_bit("tlp_ready_o", tlp_ready, 1'b0);
  endtask

  task automatic tlp_ready_flag();
    rp_bridge_pkg::tx_fifo_word_t exp;
    write_reg(rp_bridge_pkg::TX_CTRL_ADDR, 32'h2, 4'h1);         // eop
    next_cycle();
    check_bit("tlp_ready_o", tlp_ready, 1'b1);
    wait_cycles(3);
    check_bit("tlp_ready_o", tlp_ready, 1'b1);                   // holds until ack
    tlp_ack = 1'b1;
    next_cycle();
    tlp_ack = 1'b0;
    check_bit("tlp_ready_o", tlp_ready, 1'b0);
    write_reg(rp_bridge_pkg::TX_CTRL_ADDR, 32'h0, 4'h1);
    wait_cycles(2);
    check_bit("tlp_ready_o", tlp_ready, 1'b0);
    exp.eop     = 1'b1;
    exp.sop     = 1'b0;
    exp.data_hi = model_hi;
    exp.data_lo = model_lo;
    pop_tx();
    check_tx_word("tx_fifo_data_o", tx_fifo_data, exp);
    exp.eop = 1'b0;
    pop_tx();
    check_tx_word("tx_fifo_data_o", tx_fifo_data, exp);
  endtask

  task automatic tx_full_flag();
    repeat (8) write_reg(rp_bridge_pkg::TX_CTRL_ADDR, 32'h0, 4'h1);
    next_cycle();
    check_bit("tx_fifo_full_o", tx_fifo_full, 1'b0);             // count 8 is still at the level
    write_reg(rp_bridge_pkg::TX_CTRL_ADDR, 32'h0, 4'h1);
    next_cycle();
    check_bit("tx_fifo_full_o", tx_fifo_full, 1'b1);
    pop_tx();
    check_bit("tx_fifo_full_o", tx_fifo_full, 1'b0);
    repeat (8) pop_tx();
    check_bit("tlp_ready_o", tlp_ready, 1'b0);
  endtask

  task automatic rx_single_entry();
    rp_bridge_pkg::rx_fifo_word_t entry;
    entry.half_empty = 1'b1;
    entry.eop        = 1'b1;
    entry.sop        = 1'b1;
    entry.data       = random_128();
    push_rx(entry);
    wait_cycles(5);
    expect_read({8'h00, rp_bridge_pkg::RX_STATUS_OFS}, "rx status",
                status_word(8'd1, 1'b1, 1'b1));
    expect_read({8'h00, rp_bridge_pkg::RX_DATA_LO_OFS}, "rx data lo", entry.data[31:0]);
    expect_read({8'h00, rp_bridge_pkg::RX_DATA_HI_OFS}, "rx data hi", entry.data[63:32]);
    wait_cycles(4);
    // back in idle so the upper quadword never loads
    expect_read({8'h00, rp_bridge_pkg::RX_DATA_LO_OFS}, "rx data lo", entry.data[31:0]);
    expect_read({8'h00, rp_bridge_pkg::RX_STATUS_OFS}, "rx status",
                status_word(8'd1, 1'b0, 1'b0));
  endtask

  task automatic rx_two_entry_packet();
    rp_bridge_pkg::rx_fifo_word_t ent0;
    rp_bridge_pkg::rx_fifo_word_t ent1;
    rp_bridge_pkg::rx_fifo_word_t cur;
    logic [63:0]                  qw;
    int                           q;
    ent0.half_empty = 1'b0;
    ent0.eop        = 1'b0;
    ent0.sop        = 1'b1;
    ent0.data       = random_128();
    ent1.half_empty = 1'b0;
    ent1.eop        = 1'b1;
    ent1.sop        = 1'b0;
    ent1.data       = random_128();
    push_rx(ent0);
    push_rx(ent1);
    wait_cycles(5);
    for (q = 0; q < 4; q++)
    begin
      if (q < 2)
        cur = ent0;
      else
        cur = ent1;
      if (q % 2 == 0)
        qw = cur.data[63:0];
      else
        qw = cur.data[127:64];
      expect_read({8'h00, rp_bridge_pkg::RX_STATUS_OFS}, "rx status",
                  status_word((q < 2) ? 8'd2 : 8'd1, (q == 3), (q == 0)));
      expect_read({8'h00, rp_bridge_pkg::RX_DATA_LO_OFS}, "rx data lo", qw[31:0]);
      expect_read({8'h00, rp_bridge_pkg::RX_DATA_HI_OFS}, "rx data hi", qw[63:32]);
      wait_cycles(4);                     // next quadword or next pop
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial
  begin
    void'($urandom(32'hde35_dd68));
    cra_rstn     = 1'b0;
    cra_req      = '0;
    cra_wr       = 1'b0;
    cra_rd       = 1'b0;
    tx_fifo_rd   = 1'b0;
    tlp_ack      = 1'b0;
    rx_fifo_wr   = 1'b0;
    rx_fifo_data = '0;
    model_lo     = '0;
    model_hi     = '0;
    repeat (16) @(posedge cra_clk);
    #2;
    cra_rstn = 1'b1;
    next_cycle();

    reset_values();
    tx_lane_merge();
    tlp_ready_flag();
    tx_full_flag();
    rx_single_entry();
    rx_two_entry_packet();

    $display("summary: %0d errors after %0d cycles", error_count, cycle_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* rp_bridge.f */
logic/rp_bridge_pkg.sv
logic/rp_sync_fifo.sv
logic/rp_tx_regs.sv
logic/rp_rx_cpl_reader.sv
logic/rp_bridge_top.sv
dv/rp_bridge_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = rp_bridge_tb
FILELIST  = rp_bridge.f
LOG       = sim.log
FAIL_MSG  = ERRORS FOUND

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
